//--- fetch_pkg.sv
package fetch_pkg;

    // address and instruction widths
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // pc held during reset, so the first fetch lands one word later
    localparam logic [ADDR_W-1:0] DEFAULT_RESET_PC = 32'h1bfffffc;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    // one cycle of control-flow redirect strobes
    // exception over return over branch
    typedef struct packed {
        logic  br_taken;
        addr_t br_target;
        logic  br_stall;
        logic  ex_valid;
        addr_t ex_entry;
        logic  ret_valid;
        addr_t ret_pc;
    } redirect_t;

    // handed from pc generator to stage on an advance
    typedef struct packed {
        addr_t pc;
        logic  adef;
    } fetch_slot_t;

    // decode-side view of the stage
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  adef;
    } fetch_out_t;

endpackage

//--- imem_pkg.sv
package imem_pkg;

    localparam int IMEM_ADDR_W = 32;
    localparam int IMEM_DATA_W = 32;

    typedef logic [1:0] imem_size_t;

    // size is log2 of the byte count, 2 means 4 bytes
    localparam imem_size_t IMEM_SIZE_WORD = 2'b10;

    // request is a level, accepted when valid and addr_ok meet
    typedef struct packed {
        logic                   valid;
        logic [IMEM_ADDR_W-1:0] addr;
        imem_size_t             size;
    } imem_req_t;

    // data_ok is a single-cycle pulse, words come back in order
    typedef struct packed {
        logic                   addr_ok;
        logic                   data_ok;
        logic [IMEM_DATA_W-1:0] rdata;
    } imem_rsp_t;

endpackage

//--- fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*, imem_pkg::*; #(
    parameter addr_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic        clk,
    input  logic        reset,
    input  redirect_t   redirect,
    input  imem_rsp_t   imem_rsp,
    input  logic        allow_in,
    output imem_req_t   imem_req,
    output logic        advance,
    output fetch_slot_t slot,
    output logic        flush
);

    addr_t pc;
    addr_t pc_next;
    logic  adef;
    logic  run;

    // remembered redirects as flag plus target
    logic  ex_r;
    logic  ret_r;
    logic  br_r;
    addr_t ex_pc_r;
    addr_t ret_pc_r;
    addr_t br_pc_r;

    // effective redirects this cycle
    logic  ex_tak;
    logic  ret_tak;
    logic  br_tak;
    addr_t ex_pc;
    addr_t ret_pc;
    addr_t br_pc;

    // any strobe cancels whatever is in flight
    assign flush = redirect.ex_valid | redirect.ret_valid | redirect.br_taken;

    // a fresh redirect cycle overrides anything remembered
    assign ex_tak  = flush ? redirect.ex_valid  : ex_r;
    assign ret_tak = flush ? redirect.ret_valid : ret_r;
    assign br_tak  = flush ? redirect.br_taken  : br_r;
    assign ex_pc   = flush ? redirect.ex_entry  : ex_pc_r;
    assign ret_pc  = flush ? redirect.ret_pc    : ret_pc_r;
    assign br_pc   = flush ? redirect.br_target : br_pc_r;

    // fixed priority select
    always_comb begin
        if (ex_tak) begin
            pc_next = ex_pc;
        end else if (ret_tak) begin
            pc_next = ret_pc;
        end else if (br_tak) begin
            pc_next = br_pc;
        end else begin
            pc_next = pc + addr_t'(4);
        end
    end

    // misaligned fetch never goes to memory
    assign adef = pc_next[1:0] != 2'b00;

    // request only when stage can take it and nothing holds us back
    always_comb begin
        imem_req.valid = run & allow_in & ~redirect.br_stall & ~adef;
        imem_req.addr  = pc_next;
        imem_req.size  = IMEM_SIZE_WORD;
    end

    // accepted by memory or an ADEF slot that needs no memory
    assign advance = allow_in & ((imem_req.valid & imem_rsp.addr_ok) | (run & adef));

    assign slot.pc   = pc_next;
    assign slot.adef = adef;

    // low for the whole reset and high from the first cycle after
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    // flags cleared once a target address actually gets through
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_r  <= 1'b0;
            ret_r <= 1'b0;
            br_r  <= 1'b0;
        end else if (flush) begin
            ex_r  <= redirect.ex_valid;
            ret_r <= redirect.ret_valid;
            br_r  <= redirect.br_taken;
        end else if (advance) begin
            ex_r  <= 1'b0;
            ret_r <= 1'b0;
            br_r  <= 1'b0;
        end
    end

    // targets captured with every strobe cycle
    always_ff @(posedge clk) begin
        if (flush) begin
            ex_pc_r  <= redirect.ex_entry;
            ret_pc_r <= redirect.ret_pc;
            br_pc_r  <= redirect.br_target;
        end
    end

    // memory must never see a misaligned fetch
    a_req_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_req.valid |-> imem_req.addr[1:0] == 2'b00);

endmodule

//--- fetch_inst_buffer.sv
`timescale 1ns/1ps

module fetch_inst_buffer import fetch_pkg::*, imem_pkg::*; #(
    parameter int OUTSTANDING_W = 8
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      imem_accept,
    input  imem_rsp_t imem_rsp,
    input  logic      live,
    input  logic      taken,
    output logic      inst_ready,
    output inst_t     inst
);

    localparam logic [OUTSTANDING_W-1:0] CNT_ONE = OUTSTANDING_W'(1);

    logic [OUTSTANDING_W-1:0] cnt;
    logic                     match;
    logic                     hold_valid;
    inst_t                    hold_inst;

    // requests accepted but not yet answered
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (imem_accept & ~imem_rsp.data_ok) begin
            cnt <= cnt + CNT_ONE;
        end else if (~imem_accept & imem_rsp.data_ok) begin
            cnt <= cnt - CNT_ONE;
        end
    end

    // only the youngest request belongs to the occupant
    // older answers are from cancelled fetches and fall on the floor
    assign match = imem_rsp.data_ok & (cnt == CNT_ONE);

    assign inst_ready = match | (hold_valid & (cnt == '0));

    // word arrived but decode cannot take it yet
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (taken | ~live) begin
            hold_valid <= 1'b0;
        end else if (match) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (match & live & ~taken) begin
            hold_inst <= imem_rsp.rdata;
        end
    end

    assign inst = hold_valid ? hold_inst : imem_rsp.rdata;

    // a response with nothing outstanding means a broken memory model
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        imem_rsp.data_ok |-> cnt != '0);

    // too many requests in flight for the counter
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        imem_accept && !imem_rsp.data_ok |-> cnt != '1);

endmodule

//--- fetch_stage_reg.sv
`timescale 1ns/1ps

module fetch_stage_reg import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    input  fetch_slot_t slot,
    input  logic        flush,
    input  logic        inst_ready,
    input  inst_t       inst,
    input  logic        id_allow_in,
    output logic        allow_in,
    output logic        live,
    output logic        taken,
    output logic        out_valid,
    output fetch_out_t  out
);

    logic        valid;
    logic        cancel_r;
    logic        ready;
    fetch_slot_t slot_q;

    // cancel seen now or at any point since the occupant came in
    assign live = valid & ~(flush | cancel_r);

    // ADEF slot has nothing to wait for
    assign ready     = inst_ready | slot_q.adef;
    assign out_valid = live & ready;
    assign taken     = out_valid & id_allow_in;

    // empty or dead stage accepts, as does one leaving this cycle
    assign allow_in = ~live | taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (advance) begin
            valid <= ~flush;
        end else if (taken) begin
            valid <= 1'b0;
        end
    end

    // sticky until a new slot replaces the cancelled one
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_r <= 1'b0;
        end else if (advance) begin
            cancel_r <= 1'b0;
        end else if (flush) begin
            cancel_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            slot_q <= slot;
        end
    end

    // zero word for ADEF keeps the output steady under back-pressure
    assign out.pc   = slot_q.pc;
    assign out.inst = slot_q.adef ? '0 : inst;
    assign out.adef = slot_q.adef;

    // decode sees a stable word while it is stalled
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !id_allow_in |=> $stable(out));

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*, imem_pkg::*; #(
    parameter addr_t RESET_PC      = DEFAULT_RESET_PC,
    parameter int    OUTSTANDING_W = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  redirect_t  redirect,
    input  imem_rsp_t  imem_rsp,
    input  logic       id_allow_in,
    output imem_req_t  imem_req,
    output logic       out_valid,
    output fetch_out_t out
);

    // producer to consumer
    logic        advance;
    fetch_slot_t slot;
    logic        flush;
    logic        allow_in;

    // consumer to buffer
    logic        live;
    logic        taken;
    logic        inst_ready;
    inst_t       inst;

    // memory took the address, as opposed to an ADEF advance
    logic        imem_accept;

    assign imem_accept = advance & imem_req.valid;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen_i (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .imem_rsp (imem_rsp),
        .allow_in (allow_in),
        .imem_req (imem_req),
        .advance  (advance),
        .slot     (slot),
        .flush    (flush)
    );

    fetch_inst_buffer #(
        .OUTSTANDING_W (OUTSTANDING_W)
    ) inst_buffer_i (
        .clk         (clk),
        .reset       (reset),
        .imem_accept (imem_accept),
        .imem_rsp    (imem_rsp),
        .live        (live),
        .taken       (taken),
        .inst_ready  (inst_ready),
        .inst        (inst)
    );

    fetch_stage_reg stage_reg_i (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .slot        (slot),
        .flush       (flush),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .id_allow_in (id_allow_in),
        .allow_in    (allow_in),
        .live        (live),
        .taken       (taken),
        .out_valid   (out_valid),
        .out         (out)
    );

endmodule

//--- tb_fetch_checker.sv
`timescale 1ns/1ps

module tb_fetch_checker import fetch_pkg::*, imem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  redirect_t  redirect,
    input  imem_req_t  imem_req,
    input  logic       id_allow_in,
    input  logic       out_valid,
    input  fetch_out_t out,
    output int         deliveries,
    output int         checks,
    output int         errors
);

    // first fetch lands one word past the reset pc
    localparam logic [31:0] START_PC = 32'h1c000000;
    // memory model answers with the address scrambled by this key
    localparam logic [31:0] INST_KEY = 32'ha5a5a5a5;

    addr_t      exp_pc;
    logic       reset_q;
    logic       stalled;
    fetch_out_t stalled_out;

    initial begin
        deliveries = 0;
        checks     = 0;
        errors     = 0;
        reset_q    = 1'b0;
        stalled    = 1'b0;
        exp_pc     = START_PC;
    end

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t: %s expected %h got %h", $time, what, expected, got);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            // registers are only known after one edge in reset
            if (reset_q) begin
                compare("out_valid during reset", 32'(out_valid), 32'd0);
                compare("request valid during reset", 32'(imem_req.valid), 32'd0);
            end
            exp_pc  = START_PC;
            stalled = 1'b0;
        end else begin
            // misaligned address must never reach memory
            if (imem_req.valid === 1'b1) begin
                compare("request address low bits", 32'(imem_req.addr[1:0]), 32'd0);
                compare("request size", 32'(imem_req.size), 32'(IMEM_SIZE_WORD));
            end
            // word held for decode must not move while stalled
            if (stalled && out_valid === 1'b1) begin
                compare("stalled pc", out.pc, stalled_out.pc);
                compare("stalled instruction", out.inst, stalled_out.inst);
            end
            stalled     = out_valid === 1'b1 && id_allow_in === 1'b0;
            stalled_out = out;
            // one delivery per edge with both levels high
            if (out_valid === 1'b1 && id_allow_in === 1'b1) begin
                deliveries++;
                compare("delivered pc", out.pc, exp_pc);
                compare("adef bit", 32'(out.adef), 32'(exp_pc[1:0] != 2'b00));
                if (exp_pc[1:0] == 2'b00) begin
                    compare("instruction", out.inst, exp_pc ^ INST_KEY);
                end
                exp_pc = exp_pc + 32'd4;
            end
            // last redirect cycle wins with exception over return over branch
            if (redirect.ex_valid) begin
                exp_pc = redirect.ex_entry;
            end else if (redirect.ret_valid) begin
                exp_pc = redirect.ret_pc;
            end else if (redirect.br_taken) begin
                exp_pc = redirect.br_target;
            end
        end
        reset_q = reset;
    end

endmodule

//--- tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*, imem_pkg::*; ();

    localparam int          N_INST      = 2000;
    localparam int          CYCLE_LIMIT = N_INST * 20;
    localparam logic [31:0] SEED        = 32'h5fe2caed;
    localparam logic [31:0] INST_KEY    = 32'ha5a5a5a5;

    logic       clk;
    logic       reset;
    redirect_t  redirect;
    imem_rsp_t  imem_rsp;
    logic       id_allow_in;
    imem_req_t  imem_req;
    logic       out_valid;
    fetch_out_t out;

    // memory model state with accepted addresses in request order
    addr_t       pend_q[$];
    int unsigned gap;

    int          deliveries;
    int          checks;
    int          errors;
    int          cycles;
    logic        timed_out;

    fetch_top #(
        .RESET_PC      (32'h1bfffffc),
        .OUTSTANDING_W (8)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .imem_rsp    (imem_rsp),
        .id_allow_in (id_allow_in),
        .imem_req    (imem_req),
        .out_valid   (out_valid),
        .out         (out)
    );

    tb_fetch_checker checker_i (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .imem_req    (imem_req),
        .id_allow_in (id_allow_in),
        .out_valid   (out_valid),
        .out         (out),
        .deliveries  (deliveries),
        .checks      (checks),
        .errors      (errors)
    );

    // mostly aligned with about one in eight misaligned
    function automatic addr_t pick_target();
        addr_t a;
        a       = $urandom;
        a[1:0]  = 2'b00;
        if (($urandom % 8) == 0) begin
            a[1:0] = 2'($urandom % 3 + 1);
        end
        return a;
    endfunction

    function automatic redirect_t pick_redirect();
        redirect_t r;
        r.br_stall  = ($urandom % 20) == 0;
        r.br_taken  = ($urandom % 14) == 0;
        r.ex_valid  = ($urandom % 40) == 0;
        r.ret_valid = ($urandom % 40) == 0;
        r.br_target = pick_target();
        r.ex_entry  = pick_target();
        r.ret_pc    = pick_target();
        // now and then two strobes in one cycle
        if (($urandom % 64) == 0) begin
            r.br_taken  = 1'b1;
            r.ret_valid = 1'b1;
        end
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // redirects and decode back-pressure
    always @(posedge clk) begin
        if (reset) begin
            redirect    <= '0;
            id_allow_in <= 1'b0;
        end else begin
            redirect    <= pick_redirect();
            id_allow_in <= ($urandom % 4) != 0;
        end
    end

    // in-order memory with random addr_ok and 0 to 4 idle cycles between answers
    always @(posedge clk) begin
        if (reset) begin
            imem_rsp <= '0;
            pend_q.delete();
            gap = 0;
        end else begin
            if (imem_req.valid && imem_rsp.addr_ok) begin
                pend_q.push_back(imem_req.addr);
            end
            imem_rsp.addr_ok <= ($urandom % 4) != 0;
            if (pend_q.size() != 0 && gap == 0) begin
                imem_rsp.data_ok <= 1'b1;
                imem_rsp.rdata   <= pend_q.pop_front() ^ INST_KEY;
                gap = $urandom % 5;
            end else begin
                // garbage on the data lines between answers
                imem_rsp.data_ok <= 1'b0;
                imem_rsp.rdata   <= $urandom;
                if (gap != 0) begin
                    gap--;
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset       = 1'b1;
        redirect    = '0;
        imem_rsp    = '0;
        id_allow_in = 1'b0;
        cycles      = 0;
        timed_out   = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        // counts settle by the falling edge
        while (deliveries < N_INST && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("timeout: only %0d of %0d instructions delivered in %0d cycles",
                     deliveries, N_INST, cycles);
        end
        $display("deliveries %0d, checks %0d, errors %0d, timeouts %0d",
                 deliveries, checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- flist.f
fetch_pkg.sv
imem_pkg.sv
fetch_pc_gen.sv
fetch_inst_buffer.sv
fetch_stage_reg.sv
fetch_top.sv
tb_fetch_checker.sv
tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - fetch_pkg.sv
  - imem_pkg.sv
  - fetch_pc_gen.sv
  - fetch_inst_buffer.sv
  - fetch_stage_reg.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_checker.sv
      - tb_fetch.sv
